// ==== hdl/crc_pkg.sv ====
package crc_pkg;

    localparam int CRC_WIDTH   = 32;                          // CRC register width
    localparam int BYTE_WIDTH  = 8;                           // Input data width
    localparam int TABLE_DEPTH = 2 ** BYTE_WIDTH;             // One entry per byte value

    localparam logic [CRC_WIDTH-1:0] CRC_POLY   = 32'h04C11DB7;  // Ethernet generator polynomial
    localparam logic [CRC_WIDTH-1:0] CRC_INIT   = 32'hFFFFFFFF;  // State after reset and per frame
    localparam logic [CRC_WIDTH-1:0] CRC_XOROUT = 32'hFFFFFFFF;  // Final inversion mask

    // MSB-first table value for one byte, eight shift-and-xor steps
    function automatic logic [CRC_WIDTH-1:0] crc_table_entry(input logic [BYTE_WIDTH-1:0] value);
        logic [CRC_WIDTH-1:0] crc;
        crc = {value, {(CRC_WIDTH-BYTE_WIDTH){1'b0}}};       // Byte sits in the top of the word
        for (int b = 0; b < BYTE_WIDTH; b++) begin
            if (crc[CRC_WIDTH-1]) begin
                crc = (crc << 1) ^ CRC_POLY;                  // Top bit set, divide out poly
            end else begin
                crc = crc << 1;
            end
        end
        return crc;
    endfunction

    function automatic logic [BYTE_WIDTH-1:0] reflect8(input logic [BYTE_WIDTH-1:0] value);
        logic [BYTE_WIDTH-1:0] result;
        for (int b = 0; b < BYTE_WIDTH; b++) begin
            result[b] = value[BYTE_WIDTH-1-b];                // Bit 0 swaps with bit 7
        end
        return result;
    endfunction

    function automatic logic [CRC_WIDTH-1:0] reflect32(input logic [CRC_WIDTH-1:0] value);
        logic [CRC_WIDTH-1:0] result;
        for (int b = 0; b < CRC_WIDTH; b++) begin
            result[b] = value[CRC_WIDTH-1-b];                 // Full word bit reversal
        end
        return result;
    endfunction

endpackage

// ==== hdl/stream_pkg.sv ====
package stream_pkg;

    import crc_pkg::*;

    localparam int CHAN_WIDTH  = 8;                          // Channel field, caps lanes at 256
    localparam int COUNT_WIDTH = 32;                         // Completed frame counter width

    // Opcode of a beat handed to one lane
    typedef enum logic [1:0] {
        BEAT_IDLE = 2'd0,                                    // Nothing for this lane
        BEAT_DATA = 2'd1,                                    // Mid-frame byte
        BEAT_LAST = 2'd2                                     // Final byte, finish the CRC
    } beat_kind_e;

    typedef struct packed {
        beat_kind_e            kind;                         // What the lane does this cycle
        logic [BYTE_WIDTH-1:0] data;                         // Payload byte
    } lane_beat_t;

    typedef struct packed {
        logic                  done;                         // One-cycle finish pulse
        logic [CRC_WIDTH-1:0]  crc;                          // Reflected and inverted CRC
    } lane_result_t;

    typedef struct packed {
        logic                  valid;                        // Byte strobe
        logic                  last;                         // Final byte of the frame
        logic [CHAN_WIDTH-1:0] channel;                      // Target lane
        logic [BYTE_WIDTH-1:0] data;
    } in_beat_t;

    typedef struct packed {
        logic                  valid;                        // Result strobe
        logic [CHAN_WIDTH-1:0] channel;                      // Lane that finished
        logic [CRC_WIDTH-1:0]  crc;
    } crc_report_t;

endpackage

// ==== hdl/crc_dispatch.sv ====
module crc_dispatch
    import stream_pkg::*;
#(
    parameter int NUM_CHANNELS = 4                           // Number of CRC lanes
) (
    input  logic       clk,
    input  logic       reset,
    input  in_beat_t   i_beat,                               // External byte stream
    output lane_beat_t o_lane_beats [NUM_CHANNELS]           // One beat slot per lane
);

    logic [NUM_CHANNELS-1:0] lane_sel;                       // One-hot lane decode
    beat_kind_e              beat_kind;                      // Opcode for the selected lane

    assign beat_kind = i_beat.last ? BEAT_LAST : BEAT_DATA;  // Last flag picks the finish opcode

    // Channels past the last lane match nothing and fall away here
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            lane_sel[i] = i_beat.valid && (i_beat.channel == CHAN_WIDTH'(i));
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            o_lane_beats[i].data <= i_beat.data;             // Byte fans out, kind qualifies it
            if (reset) begin
                o_lane_beats[i].kind <= BEAT_IDLE;           // No lane busy out of reset
            end else if (lane_sel[i]) begin
                o_lane_beats[i].kind <= beat_kind;
            end else begin
                o_lane_beats[i].kind <= BEAT_IDLE;           // Strobe lasts a single cycle
            end
        end
    end

endmodule

// ==== hdl/crc_lane.sv ====
module crc_lane
    import crc_pkg::*, stream_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  lane_beat_t   i_beat,                             // Beat from the dispatcher
    output lane_result_t o_result                            // Finished frame CRC
);

    logic [CRC_WIDTH-1:0]  crc_table [TABLE_DEPTH];          // Precomputed byte table
    logic [CRC_WIDTH-1:0]  crc_state;                        // Running CRC of this channel
    logic [CRC_WIDTH-1:0]  crc_next;                         // State after the current byte
    logic [BYTE_WIDTH-1:0] table_index;                      // Byte folded with top of state
    logic                  beat_active;                      // DATA or LAST present
    logic                  beat_last;                        // End of frame this cycle
    logic                  result_done;
    logic [CRC_WIDTH-1:0]  result_crc;

    // Table is constant, folded at elaboration
    for (genvar g = 0; g < TABLE_DEPTH; g++) begin : g_table
        assign crc_table[g] = crc_table_entry(BYTE_WIDTH'(g));
    end

    assign beat_last   = (i_beat.kind == BEAT_LAST);
    assign beat_active = (i_beat.kind == BEAT_DATA) || beat_last;

    // Reflected input byte against the MSB byte of the state
    assign table_index = reflect8(i_beat.data) ^ crc_state[CRC_WIDTH-1 -: BYTE_WIDTH];

    always_comb begin
        crc_next = crc_state;                                // Idle holds the state
        if (beat_active) begin
            crc_next = {crc_state[CRC_WIDTH-BYTE_WIDTH-1:0], {BYTE_WIDTH{1'b0}}}
                     ^ crc_table[table_index];               // Shift a byte, fold table value
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            crc_state   <= CRC_INIT;
            result_done <= 1'b0;
        end else if (beat_last) begin
            crc_state   <= CRC_INIT;                         // Ready for the next frame
            result_done <= 1'b1;                             // Single-cycle finish pulse
        end else begin
            crc_state   <= crc_next;
            result_done <= 1'b0;
        end
    end

    // Output is reflected and inverted, only loaded at frame end
    always_ff @(posedge clk) begin
        if (beat_last) begin
            result_crc <= reflect32(crc_next) ^ CRC_XOROUT;
        end
    end

    assign o_result = '{done: result_done, crc: result_crc};

endmodule

// ==== hdl/crc_collect.sv ====
module crc_collect
    import crc_pkg::*, stream_pkg::*;
#(
    parameter int NUM_CHANNELS = 4                           // Number of CRC lanes
) (
    input  logic                   clk,
    input  logic                   reset,
    input  lane_result_t           i_results [NUM_CHANNELS], // Results from every lane
    output crc_report_t            o_report,                 // Registered external result
    output logic [COUNT_WIDTH-1:0] o_frame_count             // Frames completed since reset
);

    logic                   any_done;                        // Some lane finished this cycle
    logic [CHAN_WIDTH-1:0]  done_chan;                       // Index of the finishing lane
    logic [CRC_WIDTH-1:0]   done_crc;                        // Its CRC
    logic                   report_valid;
    logic [CHAN_WIDTH-1:0]  report_channel;
    logic [CRC_WIDTH-1:0]   report_crc;
    logic [COUNT_WIDTH-1:0] frame_count;

    // At most one done per cycle, since only one byte enters per clock
    always_comb begin
        any_done  = 1'b0;
        done_chan = '0;
        done_crc  = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (i_results[i].done) begin
                any_done  = 1'b1;
                done_chan = CHAN_WIDTH'(i);                  // Lane index is the channel
                done_crc  = i_results[i].crc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            report_valid <= 1'b0;
            frame_count  <= '0;
        end else begin
            report_valid <= any_done;                        // One-cycle report pulse
            if (any_done) begin
                frame_count <= frame_count + 1'b1;           // Count moves with the report
            end
        end
    end

    always_ff @(posedge clk) begin
        if (any_done) begin
            report_channel <= done_chan;                     // Payload only changes on a finish
            report_crc     <= done_crc;
        end
    end

    assign o_report      = '{valid: report_valid, channel: report_channel, crc: report_crc};
    assign o_frame_count = frame_count;

endmodule

// ==== hdl/crc_engine_top.sv ====
module crc_engine_top
    import stream_pkg::*;
#(
    parameter int NUM_CHANNELS = 4                           // Lanes built, at most 256
) (
    input  logic                   clk,
    input  logic                   reset,
    input  in_beat_t               i_beat,                   // Byte stream with channel tags
    output crc_report_t            o_report,                 // Finished CRC, two edges after last
    output logic [COUNT_WIDTH-1:0] o_frame_count             // Reports issued since reset
);

    lane_beat_t   lane_beats   [NUM_CHANNELS];               // Dispatcher to lanes
    lane_result_t lane_results [NUM_CHANNELS];               // Lanes to collector

    crc_dispatch #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_dispatch (
        .clk          (clk),
        .reset        (reset),
        .i_beat       (i_beat),
        .o_lane_beats (lane_beats)
    );

    // One independent CRC state per channel
    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_lane
        crc_lane u_lane (
            .clk      (clk),
            .reset    (reset),
            .i_beat   (lane_beats[g]),
            .o_result (lane_results[g])
        );
    end

    crc_collect #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_collect (
        .clk           (clk),
        .reset         (reset),
        .i_results     (lane_results),
        .o_report      (o_report),
        .o_frame_count (o_frame_count)
    );

endmodule

// ==== sim/crc_engine_chk.sv ====
module crc_engine_chk
    import stream_pkg::*;
#(
    parameter int NUM_CHANNELS = 4                           // Lanes in the bound top level
) (
    input logic                   clk,
    input logic                   reset,
    input crc_report_t            i_report,
    input logic [COUNT_WIDTH-1:0] i_frame_count
);

    int fail_count = 0;                                      // Failed assertion tally

    // Reset cycle and the one after it stay quiet
    report_quiet_in_reset: assert property (@(posedge clk) reset |=> !i_report.valid)
        else begin
            fail_count++;
            $error("report valid during reset or in the cycle after it");
        end

    channel_in_range: assert property (@(posedge clk) disable iff (reset)
        i_report.valid |-> int'(i_report.channel) < NUM_CHANNELS)
        else begin
            fail_count++;
            $error("reported channel %0d is not below %0d", i_report.channel, NUM_CHANNELS);
        end

    // Count and report move on the same edge
    count_steps_on_report: assert property (@(posedge clk) disable iff (reset)
        i_report.valid |-> i_frame_count == $past(i_frame_count) + COUNT_WIDTH'(1))
        else begin
            fail_count++;
            $error("frame count did not step by one with a report");
        end

    count_holds_when_idle: assert property (@(posedge clk) disable iff (reset)
        !i_report.valid |-> $stable(i_frame_count))
        else begin
            fail_count++;
            $error("frame count changed without a report");
        end

endmodule

bind crc_engine_top crc_engine_chk #(
    .NUM_CHANNELS  (NUM_CHANNELS)
) u_chk (
    .clk           (clk),
    .reset         (reset),
    .i_report      (o_report),
    .i_frame_count (o_frame_count)
);

// ==== sim/crc_engine_monitor.sv ====
module crc_engine_monitor
    import stream_pkg::*;
(
    input logic                   clk,
    input logic                   reset,
    input crc_report_t            i_report,                  // DUT result port
    input logic [COUNT_WIDTH-1:0] i_frame_count
);

    localparam logic [31:0] POLY_REFLECTED = 32'hEDB88320;   // 0x04C11DB7 bit reversed
    localparam logic [31:0] INIT_VALUE     = 32'hFFFFFFFF;
    localparam logic [31:0] XOR_OUT        = 32'hFFFFFFFF;

    // Expected frames, matched in order per channel
    string       exp_name [$];
    int          exp_chan [$];
    logic [31:0] exp_crc  [$];
    string       dropped  [$];                               // Frames that must not report
    string       build_name;
    int          build_chan;
    logic [31:0] build_crc;                                  // Bitwise model state
    int          pending      = 0;
    int          pass_count   = 0;
    int          error_count  = 0;
    int          report_count = 0;
    int          stray_count  = 0;

    task automatic begin_frame(input string name, input int chan);
        build_name = name;
        build_chan = chan;
        build_crc  = INIT_VALUE;
    endtask

    // LSB-first shift register, same as reflecting each byte
    task automatic add_byte(input logic [7:0] data);
        build_crc = build_crc ^ {24'h0, data};
        for (int b = 0; b < 8; b++) begin
            if (build_crc[0]) begin
                build_crc = (build_crc >> 1) ^ POLY_REFLECTED;
            end else begin
                build_crc = build_crc >> 1;
            end
        end
    endtask

    task automatic end_frame(input logic [31:0] known);
        exp_name.push_back(build_name);
        exp_chan.push_back(build_chan);
        exp_crc.push_back(known != 32'h0 ? known : build_crc ^ XOR_OUT);
        pending++;
    endtask

    task automatic expect_dropped(input string name);
        dropped.push_back(name);
    endtask

    always @(posedge clk) begin : watch
        int idx;
        if (!reset && i_report.valid) begin
            report_count++;
            idx = -1;
            for (int k = 0; k < exp_chan.size(); k++) begin
                if (idx < 0 && exp_chan[k] == int'(i_report.channel)) begin
                    idx = k;                                 // Oldest frame on this channel
                end
            end
            if (idx < 0) begin
                $display("Unexpected report on channel %0d with crc %08h",
                         i_report.channel, i_report.crc);
                stray_count++;
                error_count++;
            end else begin
                if (i_report.crc === exp_crc[idx]) begin
                    $display("PASS %s channel %0d crc %08h", exp_name[idx], exp_chan[idx],
                             i_report.crc);
                    pass_count++;
                end else begin
                    $display("** Error %s: expected crc %08h, actual %08h", exp_name[idx],
                             exp_crc[idx], i_report.crc);
                    error_count++;
                end
                exp_name.delete(idx);
                exp_chan.delete(idx);
                exp_crc.delete(idx);
                pending--;
            end
            if (i_frame_count !== COUNT_WIDTH'(report_count)) begin
                $display("** Error frame_count: expected %0d, actual %0d", report_count,
                         i_frame_count);
                error_count++;
            end
        end
    end

    task automatic list_missing();
        foreach (exp_name[k]) begin
            $display("No report came for %s on channel %0d", exp_name[k], exp_chan[k]);
        end
    endtask

    task automatic print_summary();
        foreach (dropped[k]) begin
            if (stray_count == 0) begin
                $display("PASS %s dropped without a report", dropped[k]);
                pass_count++;
            end else begin
                $display("%s: a report appeared that no frame accounts for", dropped[k]);
                error_count++;
            end
        end
        $display("Tests: %0d passed, %0d failed, %0d reports, %0d frames missing",
                 pass_count, error_count, report_count, pending);
    endtask

endmodule

// ==== sim/crc_engine_tb.sv ====
module crc_engine_tb
    import stream_pkg::*;
();

    localparam int          NUM_CHANNELS   = 4;              // Lanes built in the DUT
    localparam int          NUM_TESTS      = 14;             // Rows in the stimulus table
    localparam int          MAX_BYTES      = 256;            // Payload store for all frames
    localparam int          CLK_PERIOD     = 20;
    localparam int          DRIVE_DELAY    = 1;              // Inputs change just after the edge
    localparam int          RESET_CYCLES   = 2;
    localparam int          TIMEOUT_MARGIN = 50;             // Pipeline drain plus tail cycles
    localparam logic [31:0] SEED           = 32'h342d0aff;

    logic                   clk;
    logic                   reset;
    in_beat_t               beat;                            // Drives i_beat
    crc_report_t            report;
    logic [COUNT_WIDTH-1:0] frame_count;

    // Stimulus table, one row per frame
    string       t_name  [NUM_TESTS];
    int          t_chan  [NUM_TESTS];                        // Channel 4 and up is dropped
    int          t_len   [NUM_TESTS];                        // Frame length in bytes
    bit          t_fixed [NUM_TESTS];                        // ASCII digits instead of random
    bit          t_ilv   [NUM_TESTS];                        // Interleave with previous row
    bit          t_gaps  [NUM_TESTS];                        // Idle cycle after every byte
    logic [31:0] t_known [NUM_TESTS];                        // Known CRC, zero means use model
    int          t_start [NUM_TESTS];                        // First byte in payload store
    logic [7:0]  payload [MAX_BYTES];
    logic [31:0] rng_state;
    int          cycle_count = 0;
    int          timeout_limit;

    crc_engine_top #(
        .NUM_CHANNELS  (NUM_CHANNELS)
    ) dut (
        .clk           (clk),
        .reset         (reset),
        .i_beat        (beat),
        .o_report      (report),
        .o_frame_count (frame_count)
    );

    crc_engine_monitor mon (
        .clk           (clk),
        .reset         (reset),
        .i_report      (report),
        .i_frame_count (frame_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic set_test(input int idx, input string name, input int chan, input int len,
                            input bit fixed, input bit ilv, input bit gaps, input logic [31:0] known);
        t_name[idx]  = name;
        t_chan[idx]  = chan;
        t_len[idx]   = len;
        t_fixed[idx] = fixed;
        t_ilv[idx]   = ilv;
        t_gaps[idx]  = gaps;
        t_known[idx] = known;
    endtask

    task automatic fill_table();
        set_test(0,  "kat_123456789",  0, 9,  1, 0, 0, 32'hCBF43926);  // Standard check value
        set_test(1,  "single_ch0",     0, 1,  0, 0, 0, 32'h0);
        set_test(2,  "single_ch1",     1, 1,  0, 0, 0, 32'h0);
        set_test(3,  "single_ch2",     2, 1,  0, 0, 0, 32'h0);
        set_test(4,  "single_ch3",     3, 1,  0, 0, 0, 32'h0);
        set_test(5,  "rand_ch1",       1, 17, 0, 0, 0, 32'h0);
        set_test(6,  "rand_ch2",       2, 33, 0, 0, 0, 32'h0);
        set_test(7,  "rand_ch3",       3, 5,  0, 0, 0, 32'h0);
        set_test(8,  "ilv_ch0",        0, 12, 0, 0, 0, 32'h0);
        set_test(9,  "ilv_ch2",        2, 15, 0, 1, 0, 32'h0);  // Alternates with row 8
        set_test(10, "b2b_first_ch3",  3, 6,  0, 0, 0, 32'h0);
        set_test(11, "b2b_second_ch3", 3, 6,  0, 0, 0, 32'h0);  // Same lane right after
        set_test(12, "gaps_ch1",       1, 20, 0, 0, 1, 32'h0);
        set_test(13, "drop_ch7",       7, 3,  0, 0, 0, 32'h0);  // No lane, no report
    endtask

    // Hand one frame to the monitor before it is sent
    task automatic register_frame(input int idx);
        if (t_chan[idx] >= NUM_CHANNELS) begin
            mon.expect_dropped(t_name[idx]);
        end else begin
            mon.begin_frame(t_name[idx], t_chan[idx]);
            for (int k = 0; k < t_len[idx]; k++) begin
                mon.add_byte(payload[t_start[idx] + k]);
            end
            mon.end_frame(t_known[idx]);
        end
    endtask

    task automatic build_payloads(output int total);
        string digits;
        int    pos;
        digits = "123456789";
        pos    = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            t_start[i] = pos;
            for (int k = 0; k < t_len[i]; k++) begin
                if (t_fixed[i]) begin
                    payload[pos] = digits[k % 9];            // Digits repeat past nine bytes
                end else begin
                    rng_state    = xorshift(rng_state);
                    payload[pos] = rng_state[7:0];
                end
                pos++;
            end
            register_frame(i);
        end
        total = pos;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #DRIVE_DELAY beat = '0;
    endtask

    // One byte, then sometimes an idle cycle
    task automatic send_beat(input int chan, input logic [7:0] data, input logic last_flag,
                             input bit force_gap);
        @(posedge clk);
        #DRIVE_DELAY beat = '{valid: 1'b1, last: last_flag, channel: 8'(chan), data: data};
        rng_state = xorshift(rng_state);
        if (force_gap || rng_state[2:0] == 3'd0) begin
            drive_idle();
        end
    endtask

    task automatic send_frame(input int idx);
        for (int k = 0; k < t_len[idx]; k++) begin
            send_beat(t_chan[idx], payload[t_start[idx] + k], k == t_len[idx] - 1, t_gaps[idx]);
        end
    endtask

    // Byte by byte alternation of two frames
    task automatic send_pair(input int a, input int b);
        for (int k = 0; k < t_len[a] || k < t_len[b]; k++) begin
            if (k < t_len[a]) begin
                send_beat(t_chan[a], payload[t_start[a] + k], k == t_len[a] - 1, t_gaps[a]);
            end
            if (k < t_len[b]) begin
                send_beat(t_chan[b], payload[t_start[b] + k], k == t_len[b] - 1, t_gaps[b]);
            end
        end
    endtask

    initial begin : main
        int total;
        int i;
        reset     = 1'b1;
        beat      = '0;
        rng_state = SEED;
        fill_table();
        build_payloads(total);
        timeout_limit = RESET_CYCLES + 2 * total + TIMEOUT_MARGIN;  // At most one gap per byte
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY reset = 1'b0;
        i = 0;
        while (i < NUM_TESTS) begin
            if (i + 1 < NUM_TESTS && t_ilv[i + 1]) begin
                send_pair(i, i + 1);
                i += 2;
            end else begin
                send_frame(i);
                i++;
            end
        end
        drive_idle();
        while (mon.pending > 0) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);                           // Catch stray reports
        mon.print_summary();
        if (mon.error_count == 0 && dut.u_chk.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    always @(posedge clk) begin : watchdog
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles, some frames were never reported", cycle_count);
            mon.list_missing();
            $display("test failed");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
hdl/crc_pkg.sv
hdl/stream_pkg.sv
hdl/crc_dispatch.sv
hdl/crc_lane.sv
hdl/crc_collect.sv
hdl/crc_engine_top.sv
sim/crc_engine_chk.sv
sim/crc_engine_monitor.sv
sim/crc_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the CRC engine testbench with Verilator, run from the project root
LOG=sim.log
rm -rf obj_dir "$LOG" build.log
verilator --binary --timing --assert -f compile.f --top-module crc_engine_tb \
    -o crc_engine_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/crc_engine_sim +verilator+error+limit+100 > "$LOG" 2>&1
cat "$LOG"
grep -q "test failed" "$LOG" && exit 1
grep -q "test passed" "$LOG" || { echo "Simulation ended without a verdict"; exit 1; }
exit 0
